// File: project.f
hdl/cps_game_pkg.sv
hdl/cps_eeprom_if.sv
hdl/cps_cen_gen.sv
hdl/cps_cpu_ctrl.sv
hdl/cps_eeprom.sv
hdl/cps_game.sv
dv/cps_game_props.sv
dv/cps_game_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the cps_game testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
    --top-module cps_game_tb -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vcps_game_tb 2>&1)
sim_status=$?
printf '%s\n' "$output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1

// File: dv/cps_game_tb.sv
// Testbench for the game board timing and housekeeping slice
// Counts clock enables, exercises bus sharing and bit-bangs the settings EEPROM
`timescale 1ns/100ps
`default_nettype none

module cps_game_tb;

    localparam int WINDOW      = 240;
    localparam int READY_LIMIT = 400;
    localparam int BUS_LIMIT   = 30;

    logic clk;
    logic arst_n;
    logic turbo;
    logic cpu_speed;
    logic busreq;
    logic cen16;
    logic cen12;
    logic cen8;
    logic cpu_cen;
    logic busack;
    logic eeprom_sclk;
    logic eeprom_sdi;
    logic eeprom_scs;
    logic eeprom_sdo;

    int seed = 32'h7d1c51d0;
    int errors;
    int tests;
    int failed_tests;
    int test_first_error;

    // Model of the array contents and the write-enable latch
    cps_game_pkg::ee_word_t model_mem [cps_game_pkg::EE_WORDS];
    logic                   model_wen;

    cps_game cps_game_inst (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .turbo       ( turbo       ),
        .cpu_speed   ( cpu_speed   ),
        .busreq      ( busreq      ),
        .cen16       ( cen16       ),
        .cen12       ( cen12       ),
        .cen8        ( cen8        ),
        .cpu_cen     ( cpu_cen     ),
        .busack      ( busack      ),
        .eeprom_sclk ( eeprom_sclk ),
        .eeprom_sdi  ( eeprom_sdi  ),
        .eeprom_scs  ( eeprom_scs  ),
        .eeprom_sdo  ( eeprom_sdo  )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Expected array update for one completed non-read command
    function automatic void model_apply(input logic [1:0] op, input logic [5:0] arg,
                                        input cps_game_pkg::ee_word_t data);
        logic [1:0] ext;
        ext = arg[5:4];
        if (op == cps_game_pkg::EE_OP_EXT && ext == cps_game_pkg::EE_EXT_EWEN) begin
            model_wen = 1'b1;
        end else if (op == cps_game_pkg::EE_OP_EXT && ext == cps_game_pkg::EE_EXT_EWDS) begin
            model_wen = 1'b0;
        end else if (model_wen && op == cps_game_pkg::EE_OP_WRITE) begin
            model_mem[arg] = data;
        end else if (model_wen && op == cps_game_pkg::EE_OP_ERASE) begin
            model_mem[arg] = '1;
        end else if (model_wen) begin
            for (int i = 0; i < cps_game_pkg::EE_WORDS; i++) begin
                model_mem[i] = (ext == cps_game_pkg::EE_EXT_WRAL) ? data : '1;
            end
        end
    endfunction

    task automatic check_word(input string name, input cps_game_pkg::ee_word_t expected,
                              input cps_game_pkg::ee_word_t actual);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            errors++;
            $display("Mismatch %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors == test_first_error) begin
            $display("Test %0d %s: pass", tests, name);
        end else begin
            failed_tests++;
            $display("Test %0d %s: fail, %0d errors", tests, name, errors - test_first_error);
        end
        test_first_error = errors;
    endtask

    task automatic cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // Window starts on the first cen16 seen
    task automatic count_enables(output int n16, output int n12, output int n8,
                                 output int ncpu);
        int guard;
        guard = 0;
        n16 = 0;
        n12 = 0;
        n8 = 0;
        ncpu = 0;
        @(negedge clk);
        while (cen16 !== 1'b1 && guard < 2 * cps_game_pkg::CEN_PERIOD) begin
            guard++;
            @(negedge clk);
        end
        if (cen16 !== 1'b1) begin
            errors++;
            $display("Error: no cen16 pulse within %0d cycles", guard);
        end
        for (int i = 0; i < WINDOW; i++) begin
            n16 += int'(cen16);
            n12 += int'(cen12);
            n8 += int'(cen8);
            ncpu += int'(cpu_cen);
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic wait_busack(input logic level, input string name);
        int n;
        n = 0;
        @(negedge clk);
        while (busack !== level && n < BUS_LIMIT) begin
            n++;
            @(negedge clk);
        end
        if (busack !== level) begin
            errors++;
            $display("Error: %s did not happen within %0d cycles", name, BUS_LIMIT);
        end
        @(posedge clk);
    endtask

    // One sclk period, sdi changes while sclk is low
    task automatic sclk_bit(input logic b);
        eeprom_sdi  <= b;
        eeprom_sclk <= 1'b0;
        cycles(5);
        eeprom_sclk <= 1'b1;
        cycles(5);
    endtask

    task automatic send_header(input logic [1:0] op, input logic [5:0] arg);
        cps_game_pkg::ee_cmd_t cmd;
        cmd = {op, arg};
        eeprom_scs  <= 1'b1;
        eeprom_sclk <= 1'b0;
        eeprom_sdi  <= 1'b0;
        cycles(5);
        sclk_bit(1'b1);
        for (int i = 7; i >= 0; i--) begin
            sclk_bit(cmd[i]);
        end
    endtask

    task automatic end_cmd();
        eeprom_scs  <= 1'b0;
        eeprom_sclk <= 1'b0;
        eeprom_sdi  <= 1'b0;
        cycles(6);
    endtask

    // Select high shows ready on sdo, count the cycles until it is set
    task automatic wait_ready(output int busy_cycles);
        busy_cycles = 0;
        eeprom_scs <= 1'b1;
        @(negedge clk);
        while (eeprom_sdo !== 1'b1 && busy_cycles < READY_LIMIT) begin
            busy_cycles++;
            @(negedge clk);
        end
        if (eeprom_sdo !== 1'b1) begin
            errors++;
            $display("Error: EEPROM still busy after %0d cycles", READY_LIMIT);
        end
        @(posedge clk);
        end_cmd();
    endtask

    task automatic ee_op(input logic [1:0] op, input logic [5:0] arg,
                         input cps_game_pkg::ee_word_t data, output int busy_cycles);
        send_header(op, arg);
        if (op == cps_game_pkg::EE_OP_WRITE ||
            (op == cps_game_pkg::EE_OP_EXT && arg[5:4] == cps_game_pkg::EE_EXT_WRAL)) begin
            for (int i = 15; i >= 0; i--) begin
                sclk_bit(data[i]);
            end
        end
        end_cmd();
        wait_ready(busy_cycles);
        model_apply(op, arg, data);
    endtask

    // Dummy zero shows after the address, data bits follow one per sclk
    task automatic read_check(input string name, input cps_game_pkg::ee_addr_t addr);
        cps_game_pkg::ee_word_t data;
        send_header(cps_game_pkg::EE_OP_READ, addr);
        for (int i = 15; i >= 0; i--) begin
            sclk_bit(1'b0);
            @(negedge clk);
            data[i] = eeprom_sdo;
            @(posedge clk);
        end
        end_cmd();
        check_word(name, model_mem[addr], data);
    endtask

    initial begin
        cps_game_pkg::ee_addr_t addrs [8];
        int rnd;
        int busy;
        int lows;
        int n16;
        int n12;
        int n8;
        int ncpu;
        errors = 0;
        tests = 0;
        failed_tests = 0;
        test_first_error = 0;
        model_wen = 1'b0;
        for (int i = 0; i < cps_game_pkg::EE_WORDS; i++) begin
            model_mem[i] = '1;
        end
        arst_n      <= 1'b0;
        turbo       <= 1'b0;
        cpu_speed   <= 1'b0;
        busreq      <= 1'b0;
        eeprom_sclk <= 1'b0;
        eeprom_sdi  <= 1'b0;
        eeprom_scs  <= 1'b0;
        cycles(8);
        arst_n <= 1'b1;

        count_enables(n16, n12, n8, ncpu);
        check_count("cen16 pulses", WINDOW / 3, n16);
        check_count("cen12 pulses", WINDOW / 4, n12);
        check_count("cen8 pulses", WINDOW / 6, n8);
        check_count("cpu_cen slow pulses", WINDOW / 4 * cps_game_pkg::CPU_SLOW_KEEP /
                    cps_game_pkg::CPU_SLOW_OF, ncpu);
        cpu_speed <= 1'b1;
        cycles(8);
        count_enables(n16, n12, n8, ncpu);
        check_count("cpu_cen fast pulses", WINDOW / 4, ncpu);
        cpu_speed <= 1'b0;
        finish_test("clock enables");

        busreq <= 1'b1;
        wait_busack(1'b1, "busack rise");
        busreq <= 1'b0;
        wait_busack(1'b0, "busack fall");
        turbo <= 1'b1;
        lows = 0;
        for (int i = 0; i < 60; i++) begin
            rnd = $random(seed);
            busreq <= rnd[0];
            @(negedge clk);
            lows += int'(busack !== 1'b1);
            @(posedge clk);
        end
        check_count("busack low cycles in turbo", 0, lows);
        turbo  <= 1'b0;
        busreq <= 1'b0;
        cycles(10);
        finish_test("bus sharing");

        rnd = $random(seed);
        ee_op(cps_game_pkg::EE_OP_WRITE, rnd[5:0], rnd[31:16], busy);
        check_count("busy cycles of protected write", 0, busy);
        read_check("read after protected write", rnd[5:0]);
        finish_test("write protection");

        ee_op(cps_game_pkg::EE_OP_EXT, {cps_game_pkg::EE_EXT_EWEN, 4'h0}, '0, busy);
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            addrs[i] = rnd[5:0];
            ee_op(cps_game_pkg::EE_OP_WRITE, addrs[i], rnd[31:16], busy);
        end
        for (int i = 0; i < 8; i++) begin
            read_check("read back", addrs[i]);
        end
        finish_test("write and read back");

        ee_op(cps_game_pkg::EE_OP_ERASE, addrs[0], '0, busy);
        read_check("read after erase", addrs[0]);
        rnd = $random(seed);
        ee_op(cps_game_pkg::EE_OP_EXT, {cps_game_pkg::EE_EXT_WRAL, 4'h0}, rnd[15:0], busy);
        for (int i = 1; i < 5; i++) begin
            read_check("read after WRAL", addrs[i]);
        end
        ee_op(cps_game_pkg::EE_OP_EXT, {cps_game_pkg::EE_EXT_ERAL, 4'h0}, '0, busy);
        read_check("read after ERAL", addrs[5]);
        ee_op(cps_game_pkg::EE_OP_EXT, {cps_game_pkg::EE_EXT_EWDS, 4'h0}, '0, busy);
        ee_op(cps_game_pkg::EE_OP_WRITE, addrs[6], rnd[31:16], busy);
        read_check("read after write with EWDS", addrs[6]);
        finish_test("erase, bulk and disable");

        $display("Tests run: %0d, tests failed: %0d, errors: %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/cps_game_props.sv
// Checks on the main CPU clock enable and the bus grant rules
// Bound into the CPU control block
`timescale 1ns/100ps
`default_nettype none

module cps_game_props (
    input logic clk,
    input logic arst_n,
    input logic cen12,
    input logic turbo,
    input logic cpu_cen,
    input logic busack
);

    // Turbo keeps the bus granted and passes every cen12 pulse on
    turbo_overrides: assert property (
        @(posedge clk) disable iff (!arst_n)
        turbo && $past(turbo) |-> busack && cpu_cen == $past(cen12)
    ) else $error("turbo did not hold busack or pass cen12 through");

    // Without turbo the grant moves only on a CPU cycle boundary
    grant_on_cpu_cen: assert property (
        @(posedge clk) disable iff (!arst_n)
        !turbo && !$past(turbo) && busack != $past(busack) |-> $past(cpu_cen)
    ) else $error("busack changed without a cpu_cen one cycle earlier");

    // CPU strobe trails a cen12 strobe and never comes closer than 4 cycles
    cpu_cen_after_cen12: assert property (
        @(posedge clk) disable iff (!arst_n)
        cpu_cen |-> $past(cen12) && !$past(cpu_cen) &&
                    !$past(cpu_cen, 2) && !$past(cpu_cen, 3)
    ) else $error("cpu_cen without cen12 one cycle earlier or too close to the last");

endmodule

bind cps_cpu_ctrl cps_game_props props_inst (
    .clk     ( clk     ),
    .arst_n  ( arst_n  ),
    .cen12   ( cen12   ),
    .turbo   ( turbo   ),
    .cpu_cen ( cpu_cen ),
    .busack  ( busack  )
);

`default_nettype wire

// File: hdl/cps_game.sv
// Game board top level, timing and housekeeping slice
// Clock enables, main CPU rate with turbo bus rule, settings EEPROM
`timescale 1ns/100ps
`default_nettype none

module cps_game (
    input  logic clk,
    input  logic arst_n,
    input  logic turbo,
    input  logic cpu_speed,
    input  logic busreq,
    output logic cen16,
    output logic cen12,
    output logic cen8,
    output logic cpu_cen,
    output logic busack,
    // EEPROM pins from the main CPU
    input  logic eeprom_sclk,
    input  logic eeprom_sdi,
    input  logic eeprom_scs,
    output logic eeprom_sdo
);

    cps_eeprom_if eeprom_if ();

    assign eeprom_if.sclk = eeprom_sclk;
    assign eeprom_if.sdi  = eeprom_sdi;
    assign eeprom_if.scs  = eeprom_scs;
    assign eeprom_sdo     = eeprom_if.sdo;

    cps_cen_gen u_cen (
        .clk       ( clk        ),
        .arst_n    ( arst_n     ),
        .cen16     ( cen16      ),
        .cen12     ( cen12      ),
        .cen8      ( cen8       )
    );

    // CPU rate derives from cen12
    cps_cpu_ctrl u_cpu_ctrl (
        .clk       ( clk        ),
        .arst_n    ( arst_n     ),
        .cen12     ( cen12      ),
        .cpu_speed ( cpu_speed  ),
        .turbo     ( turbo      ),
        .busreq    ( busreq     ),
        .cpu_cen   ( cpu_cen    ),
        .busack    ( busack     )
    );

    cps_eeprom u_eeprom (
        .clk       ( clk        ),
        .arst_n    ( arst_n     ),
        .pins      ( eeprom_if  )
    );

endmodule

`default_nettype wire

// File: hdl/cps_eeprom.sv
// 93C46-style serial settings EEPROM, 64 words of 16 bits
// Handles read, write, erase, bulk write/erase and the write-enable latch,
// with a fixed busy period after every change to the array
`timescale 1ns/100ps
`default_nettype none

module cps_eeprom (
    input  logic        clk,
    input  logic        arst_n,
    cps_eeprom_if.chip  pins
);

    logic [2:0] sync1;
    logic [2:0] sync2;
    logic       sclk_l;
    logic       sclk_rise;
    logic       sdi_s;
    logic       scs_s;

    logic [2:0]                st;
    logic [4:0]                bit_cnt;
    cps_game_pkg::ee_cmd_t     cmd;
    cps_game_pkg::ee_cmd_t     cmd_next;
    cps_game_pkg::ee_word_t    data_sr;
    logic [16:0]               rd_sr;
    logic                      wen;
    logic                      wr_pend;
    logic                      wr_all;
    cps_game_pkg::ee_addr_t    wr_addr;
    cps_game_pkg::ee_word_t    wr_data;
    logic [7:0]                busy_cnt;
    logic                      op_go;
    logic                      rd_load;
    logic                      data_shift;

    cps_game_pkg::ee_word_t mem [cps_game_pkg::EE_WORDS];

    // Two-flop synchronizer on all serial inputs, then sclk edge detect
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sync1  <= 3'd0;
            sync2  <= 3'd0;
            sclk_l <= 1'b0;
        end else begin
            sync1  <= {pins.sclk, pins.sdi, pins.scs};
            sync2  <= sync1;
            sclk_l <= sync2[2];
        end
    end

    assign sclk_rise = sync2[2] & ~sclk_l;
    assign sdi_s     = sync2[1];
    assign scs_s     = sync2[0];

    assign cmd_next = {cmd[6:0], sdi_s};

    // Last address bit of a READ loads the output shifter
    assign rd_load = st == cps_game_pkg::EE_ST_CMD && scs_s && sclk_rise &&
                     bit_cnt == 5'd7 && cmd_next.std.op == cps_game_pkg::EE_OP_READ;

    assign data_shift = st == cps_game_pkg::EE_ST_DATA && scs_s && sclk_rise &&
                        bit_cnt != 5'd16;

    // Completed command when select drops
    assign op_go = !scs_s &&
                   ((st == cps_game_pkg::EE_ST_CMD && bit_cnt == 5'd8) ||
                    (st == cps_game_pkg::EE_ST_DATA && bit_cnt == 5'd16));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            st       <= cps_game_pkg::EE_ST_IDLE;
            bit_cnt  <= 5'd0;
            cmd      <= '0;
            wen      <= 1'b0;
            wr_pend  <= 1'b0;
            wr_all   <= 1'b0;
            wr_addr  <= '0;
            busy_cnt <= 8'd0;
        end else begin
            case (st)
                cps_game_pkg::EE_ST_IDLE: begin
                    bit_cnt <= 5'd0;
                    // Leading zeros are skipped until the start bit
                    if (scs_s && sclk_rise && sdi_s) begin
                        st <= cps_game_pkg::EE_ST_CMD;
                    end
                end
                cps_game_pkg::EE_ST_CMD: begin
                    if (!scs_s) begin
                        st <= cps_game_pkg::EE_ST_IDLE;
                    end else if (sclk_rise && bit_cnt != 5'd8) begin
                        cmd     <= cmd_next;
                        bit_cnt <= bit_cnt + 5'd1;
                        if (bit_cnt == 5'd7) begin
                            if (cmd_next.std.op == cps_game_pkg::EE_OP_READ) begin
                                st <= cps_game_pkg::EE_ST_READ;
                            end else if (cmd_next.std.op == cps_game_pkg::EE_OP_WRITE ||
                                         (cmd_next.ext.op == cps_game_pkg::EE_OP_EXT &&
                                          cmd_next.ext.ext == cps_game_pkg::EE_EXT_WRAL)) begin
                                st      <= cps_game_pkg::EE_ST_DATA;
                                bit_cnt <= 5'd0;
                            end
                        end
                    end
                end
                cps_game_pkg::EE_ST_READ: begin
                    if (!scs_s) begin
                        st <= cps_game_pkg::EE_ST_IDLE;
                    end
                end
                cps_game_pkg::EE_ST_DATA: begin
                    if (!scs_s) begin
                        st <= cps_game_pkg::EE_ST_IDLE;
                    end else if (data_shift) begin
                        bit_cnt <= bit_cnt + 5'd1;
                    end
                end
                default: begin
                    // Busy: one array word per cycle while a write is pending
                    if (wr_pend) begin
                        wr_addr <= wr_addr + 1'b1;
                        if (!wr_all ||
                            wr_addr == cps_game_pkg::ee_addr_t'(cps_game_pkg::EE_WORDS - 1)) begin
                            wr_pend <= 1'b0;
                        end
                    end
                    if (busy_cnt == 8'd0) begin
                        st <= cps_game_pkg::EE_ST_IDLE;
                    end else begin
                        busy_cnt <= busy_cnt - 8'd1;
                    end
                end
            endcase

            if (op_go) begin
                if (cmd.ext.op == cps_game_pkg::EE_OP_EXT &&
                    cmd.ext.ext == cps_game_pkg::EE_EXT_EWEN) begin
                    wen <= 1'b1;
                end else if (cmd.ext.op == cps_game_pkg::EE_OP_EXT &&
                             cmd.ext.ext == cps_game_pkg::EE_EXT_EWDS) begin
                    wen <= 1'b0;
                end else if (wen) begin
                    // Write, erase, WRAL or ERAL
                    st       <= cps_game_pkg::EE_ST_BUSY;
                    busy_cnt <= 8'(cps_game_pkg::EE_BUSY_CYCLES - 1);
                    wr_pend  <= 1'b1;
                    wr_all   <= cmd.std.op == cps_game_pkg::EE_OP_EXT;
                    wr_addr  <= (cmd.std.op == cps_game_pkg::EE_OP_EXT) ? '0 : cmd.std.addr;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (data_shift) begin
            data_sr <= {data_sr[14:0], sdi_s};
        end
        // Erase variants store all ones
        if (op_go) begin
            wr_data <= (st == cps_game_pkg::EE_ST_DATA) ? data_sr : '1;
        end
        if (rd_load) begin
            rd_sr <= {1'b0, mem[cmd_next.std.addr]};
        end else if (st == cps_game_pkg::EE_ST_READ && sclk_rise) begin
            rd_sr <= {rd_sr[15:0], 1'b0};
        end
    end

    // Array starts out fully erased
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < cps_game_pkg::EE_WORDS; i++) begin
                mem[i] <= '1;
            end
        end else if (st == cps_game_pkg::EE_ST_BUSY && wr_pend) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Data during read-out, ready level otherwise
    assign pins.sdo = (st == cps_game_pkg::EE_ST_READ) ? rd_sr[16] :
                      (st != cps_game_pkg::EE_ST_BUSY);

endmodule

`default_nettype wire

// File: hdl/cps_cpu_ctrl.sv
// Main CPU clock enable and bus sharing
// Thins cen12 down to 10 MHz unless fast or turbo is selected,
// and grants the bus to video DMA only at CPU cycle boundaries
`timescale 1ns/100ps
`default_nettype none

module cps_cpu_ctrl (
    input  logic clk,
    input  logic arst_n,
    input  logic cen12,
    input  logic cpu_speed,
    input  logic turbo,
    input  logic busreq,
    output logic cpu_cen,
    output logic busack
);

    logic [2:0] slow_cnt;
    logic       fast;
    logic       keep;
    logic       bus_grant;

    assign fast = cpu_speed | turbo;

    // Slow mode lets 5 out of 6 cen12 pulses through
    assign keep = fast || (slow_cnt < 3'(cps_game_pkg::CPU_SLOW_KEEP));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slow_cnt <= 3'd0;
            cpu_cen  <= 1'b0;
        end else begin
            cpu_cen <= cen12 & keep;
            if (cen12) begin
                if (slow_cnt == 3'(cps_game_pkg::CPU_SLOW_OF - 1)) begin
                    slow_cnt <= 3'd0;
                end else begin
                    slow_cnt <= slow_cnt + 3'd1;
                end
            end
        end
    end

    // Grant follows the request, sampled when the CPU advances
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bus_grant <= 1'b0;
        end else if (cpu_cen) begin
            bus_grant <= busreq & ~turbo;
        end
    end

    // A turbo CPU never yields, so DMA always sees the bus as granted
    assign busack = bus_grant | turbo;

endmodule

`default_nettype wire

// File: hdl/cps_cen_gen.sv
// Clock-enable generator
// Derives 16, 12 and 8 MHz one-cycle strobes from the 48 MHz clock
`timescale 1ns/100ps
`default_nettype none

module cps_cen_gen (
    input  logic clk,
    input  logic arst_n,
    output logic cen16,
    output logic cen12,
    output logic cen8
);

    logic [3:0] phase;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase <= 4'd0;
            cen16 <= 1'b0;
            cen12 <= 1'b0;
            cen8  <= 1'b0;
        end else begin
            if (phase == 4'(cps_game_pkg::CEN_PERIOD - 1)) begin
                phase <= 4'd0;
            end else begin
                phase <= phase + 4'd1;
            end

            // All three strobes line up on phase zero
            cen16 <= phase == 4'd0 || phase == 4'd3 ||
                     phase == 4'd6 || phase == 4'd9;
            cen12 <= phase == 4'd0 || phase == 4'd4 || phase == 4'd8;
            cen8  <= phase == 4'd0 || phase == 4'd6;
        end
    end

endmodule

`default_nettype wire

// File: hdl/cps_eeprom_if.sv
// Serial pins of the settings EEPROM
// Host drives clock, data and select, chip returns data and ready
`timescale 1ns/100ps
`default_nettype none

interface cps_eeprom_if;

    logic sclk;
    logic sdi;
    logic scs;
    // Data out, or ready while not reading
    logic sdo;

    modport host (
        output sclk,
        output sdi,
        output scs,
        input  sdo
    );

    modport chip (
        input  sclk,
        input  sdi,
        input  scs,
        output sdo
    );

endinterface

`default_nettype wire

// File: hdl/cps_game_pkg.sv
// Shared sizes, timing constants and EEPROM command encodings
// for the arcade board timing and housekeeping slice
`default_nettype none

package cps_game_pkg;

    // EEPROM geometry
    localparam int EE_WORDS = 64;

    typedef logic [15:0] ee_word_t;
    typedef logic [5:0]  ee_addr_t;

    // Opcodes following the start bit
    localparam logic [1:0] EE_OP_READ  = 2'b10;
    localparam logic [1:0] EE_OP_WRITE = 2'b01;
    localparam logic [1:0] EE_OP_ERASE = 2'b11;
    localparam logic [1:0] EE_OP_EXT   = 2'b00;

    // Extended codes, only when the opcode is zero
    localparam logic [1:0] EE_EXT_EWDS = 2'b00;
    localparam logic [1:0] EE_EXT_WRAL = 2'b01;
    localparam logic [1:0] EE_EXT_ERAL = 2'b10;
    localparam logic [1:0] EE_EXT_EWEN = 2'b11;

    typedef struct packed {
        logic [1:0] op;
        ee_addr_t   addr;
    } ee_cmd_std_t;

    typedef struct packed {
        logic [1:0] op;
        logic [1:0] ext;
        logic [3:0] dc;
    } ee_cmd_ext_t;

    typedef union packed {
        ee_cmd_std_t std;
        ee_cmd_ext_t ext;
    } ee_cmd_t;

    // EEPROM serial FSM states
    localparam logic [2:0] EE_ST_IDLE = 3'd0;
    localparam logic [2:0] EE_ST_CMD  = 3'd1;
    localparam logic [2:0] EE_ST_READ = 3'd2;
    localparam logic [2:0] EE_ST_DATA = 3'd3;
    localparam logic [2:0] EE_ST_BUSY = 3'd4;

    localparam int EE_BUSY_CYCLES = 200;

    // Clock-enable pattern and CPU thinning
    localparam int CEN_PERIOD    = 12;
    localparam int CPU_SLOW_KEEP = 5;
    localparam int CPU_SLOW_OF   = 6;

endpackage

`default_nettype wire
